/* branch_predictor.sv */
// Direct-mapped target buffer with 2-bit counters. Lookup result appears one
// cycle after fetch_ce; register-indirect branches are never allocated.
`default_nettype none

module branch_predictor #(
   parameter int P_BTB_NUM = 4,
   parameter int P_SLOTS   = 2
) (
   input  logic                                clk,
   input  logic                                arst_n,
   input  logic                                fetch_ce,
   input  frontend_pkg::pc_t [P_SLOTS-1:0]     slot_pc,
   input  frontend_pkg::bpu_wb_t               wb,
   output frontend_pkg::pred_t [P_SLOTS-1:0]   pred
);
   localparam int NUM = 1 << P_BTB_NUM;
   localparam int TW  = frontend_pkg::pc_w - P_BTB_NUM;

   logic [NUM-1:0]        ent_vld;
   logic [TW-1:0]         ent_tag [NUM];
   frontend_pkg::pc_t     ent_tgt [NUM];
   logic [1:0]            ent_cnt [NUM];

   logic [P_BTB_NUM-1:0]  lk_idx [P_SLOTS];
   logic [P_SLOTS-1:0]    lk_hit;
   logic [P_SLOTS-1:0]    taken_q;
   frontend_pkg::pc_t     tgt_q [P_SLOTS];

   logic [P_BTB_NUM-1:0]  wb_idx;
   logic [TW-1:0]         wb_tag;
   logic                  wb_hit;
   logic                  wb_dir;

   // Per-slot lookup
   always_comb
   begin
      for (int i = 0; i < P_SLOTS; i++)
      begin
         lk_idx[i] = slot_pc[i][P_BTB_NUM-1:0];
         lk_hit[i] = ent_vld[lk_idx[i]] &&
                     (ent_tag[lk_idx[i]] == slot_pc[i][frontend_pkg::pc_w-1:P_BTB_NUM]);
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         taken_q <= '0;
      else if (fetch_ce)
      begin
         for (int i = 0; i < P_SLOTS; i++)
            taken_q[i] <= lk_hit[i] & ent_cnt[lk_idx[i]][1];
      end
   end

   always_ff @(posedge clk)
   begin
      if (fetch_ce)
      begin
         for (int i = 0; i < P_SLOTS; i++)
            tgt_q[i] <= ent_tgt[lk_idx[i]];
      end
   end

   always_comb
   begin
      for (int i = 0; i < P_SLOTS; i++)
      begin
         pred[i].taken  = taken_q[i];
         pred[i].target = tgt_q[i];
      end
   end

   // Training from execute
   assign wb_idx = wb.pc[P_BTB_NUM-1:0];
   assign wb_tag = wb.pc[frontend_pkg::pc_w-1:P_BTB_NUM];
   assign wb_hit = ent_vld[wb_idx] && (ent_tag[wb_idx] == wb_tag);
   assign wb_dir = (wb.kind != frontend_pkg::BR_REG);

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         ent_vld <= '0;
      else if (wb.valid && wb.taken && wb_dir && !wb_hit)
         ent_vld[wb_idx] <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (wb.valid && wb.taken && wb_dir)
      begin
         ent_tgt[wb_idx] <= wb.npc_act;
         if (wb_hit)
         begin
            if (ent_cnt[wb_idx] != 2'd3)
               ent_cnt[wb_idx] <= ent_cnt[wb_idx] + 2'd1;
         end
         else
         begin
            // New entry starts weakly taken
            ent_tag[wb_idx] <= wb_tag;
            ent_cnt[wb_idx] <= 2'd2;
         end
      end
      else if (wb.valid && !wb.taken && wb_hit)
      begin
         if (ent_cnt[wb_idx] != 2'd0)
            ent_cnt[wb_idx] <= ent_cnt[wb_idx] - 2'd1;
      end
   end

   a_wb_kind_legal : assert property (@(posedge clk) disable iff (!arst_n)
      wb.valid |-> wb.kind inside {frontend_pkg::BR_COND, frontend_pkg::BR_REL,
                                   frontend_pkg::BR_REG});

endmodule

`default_nettype wire

/* fetch_pc_gen.sv */
// Next-PC selection and window alignment. Window width is 1 to 4 slots;
// imem_addr is always aligned to the window.
`default_nettype none

module fetch_pc_gen #(
   parameter int                P_FETCH_W = 1,
   parameter frontend_pkg::pc_t PC_RST    = '0
) (
   input  logic                                    clk,
   input  logic                                    arst_n,
   input  logic                                    flush,
   input  frontend_pkg::pc_t                       flush_tgt,
   input  logic                                    iq_ready,
   input  logic                                    redirect_taken,
   input  frontend_pkg::pc_t                       redirect_tgt,
   input  logic [P_FETCH_W:0]                      seq_cnt,
   output logic                                    fetch_ce,
   output logic [31:0]                             imem_addr,
   output frontend_pkg::pc_t [(1<<P_FETCH_W)-1:0] slot_pc,
   output logic [(1<<P_FETCH_W)-1:0]               aligned,
   output logic [P_FETCH_W:0]                      push_offset
);
   localparam int FW = 1 << P_FETCH_W;

   frontend_pkg::pc_t pc_q;
   frontend_pkg::pc_t pc_nxt;
   frontend_pkg::pc_t win_off;
   frontend_pkg::pc_t win_base;

   assign fetch_ce = iq_ready;

   // Flush wins, then hold, then predicted target, then sequential step
   always_comb
   begin
      if (flush)
         pc_nxt = flush_tgt;
      else if (!fetch_ce)
         pc_nxt = pc_q;
      else if (redirect_taken)
         pc_nxt = redirect_tgt;
      else
         pc_nxt = pc_q + frontend_pkg::pc_t'(seq_cnt);
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         pc_q <= PC_RST;
      else
         pc_q <= pc_nxt;
   end

   // Slot position of the PC inside its window
   assign win_off     = pc_nxt & frontend_pkg::pc_t'(FW - 1);
   assign win_base    = pc_nxt - win_off;
   assign imem_addr   = {win_base, 2'b00};
   assign push_offset = win_off[P_FETCH_W:0];

   generate
      for (genvar i = 0; i < FW; i++)
      begin : g_slot
         assign slot_pc[i] = win_base + frontend_pkg::pc_t'(i);
         // Slots before the PC are dropped
         assign aligned[i] = (win_off <= frontend_pkg::pc_t'(i));
      end
   endgenerate

   // Without a redirect the sequential step ends on a window boundary
   a_seq_step_window : assert property (@(posedge clk) disable iff (!arst_n)
      (fetch_ce && !flush && !redirect_taken && seq_cnt != '0) |-> (win_off == '0));

endmodule

`default_nettype wire

/* fetch_slot_stage.sv */
// Stage registers between memory and queue. Memory words arrive with stage one
// and are captured into stage two together with the PCs and predictions.
`default_nettype none

module fetch_slot_stage #(
   parameter int P_FETCH_W = 1
) (
   input  logic                                          clk,
   input  logic                                          arst_n,
   input  logic                                          fetch_ce,
   input  logic                                          flush,
   input  frontend_pkg::pc_t [(1<<P_FETCH_W)-1:0]        slot_pc,
   input  logic [(1<<P_FETCH_W)-1:0]                     aligned,
   input  logic [P_FETCH_W:0]                            push_offset,
   input  frontend_pkg::pred_t [(1<<P_FETCH_W)-1:0]      pred,
   input  frontend_pkg::insn_t [(1<<P_FETCH_W)-1:0]      imem_rdata,
   output logic                                          redirect_taken,
   output frontend_pkg::pc_t                             redirect_tgt,
   output logic [P_FETCH_W:0]                            seq_cnt,
   output logic [P_FETCH_W:0]                            iq_push_cnt,
   output logic [P_FETCH_W:0]                            iq_push_offset,
   output frontend_pkg::fetch_slot_t [(1<<P_FETCH_W)-1:0] iq_slots
);
   localparam int FW = 1 << P_FETCH_W;
   localparam int CW = P_FETCH_W + 1;

   // Stage one
   logic [FW-1:0]                    s1_aligned;
   frontend_pkg::pc_t [FW-1:0]       s1_pc;
   logic [CW-1:0]                    s1_offset;
   logic [FW-1:0]                    slot_vld;
   logic [FW-1:0]                    prior_taken;

   // Stage two
   logic [CW-1:0]                    s2_push_cnt;
   logic [CW-1:0]                    s2_offset;
   frontend_pkg::pc_t [FW-1:0]       s2_pc;
   frontend_pkg::pred_t [FW-1:0]     s2_pred;
   frontend_pkg::insn_t [FW-1:0]     s2_ins;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         s1_aligned  <= '0;
         s2_push_cnt <= '0;
      end
      else if (fetch_ce || flush)
      begin
         // Flush kills both windows in flight
         s1_aligned  <= flush ? '0 : aligned;
         s2_push_cnt <= flush ? '0 : seq_cnt;
      end
   end

   always_ff @(posedge clk)
   begin
      if (fetch_ce)
      begin
         s1_pc     <= slot_pc;
         s1_offset <= push_offset;
         s2_pc     <= s1_pc;
         s2_offset <= s1_offset;
         s2_pred   <= pred;
         s2_ins    <= imem_rdata;
      end
   end

   // A slot survives only if no earlier live slot predicts taken
   always_comb
   begin
      prior_taken[0] = 1'b0;
      for (int i = 1; i < FW; i++)
         prior_taken[i] = prior_taken[i-1] | (slot_vld[i-1] & pred[i-1].taken);
   end

   assign slot_vld = s1_aligned & ~prior_taken;

   always_comb
   begin
      redirect_taken = 1'b0;
      redirect_tgt   = pred[0].target;
      seq_cnt        = '0;
      for (int i = 0; i < FW; i++)
      begin
         if (slot_vld[i] && pred[i].taken)
         begin
            redirect_taken = 1'b1;
            redirect_tgt   = pred[i].target;
         end
         seq_cnt = seq_cnt + CW'(slot_vld[i]);
      end
   end

   // Push only while the frontend advances
   assign iq_push_cnt    = fetch_ce ? s2_push_cnt : '0;
   assign iq_push_offset = s2_offset;

   generate
      for (genvar i = 0; i < FW; i++)
      begin : g_pack
         assign iq_slots[i].pc   = s2_pc[i];
         assign iq_slots[i].ins  = s2_ins[i];
         assign iq_slots[i].pred = s2_pred[i];
      end
   endgenerate

endmodule

`default_nettype wire

/* frontend.f */
frontend_pkg.sv
fetch_pc_gen.sv
branch_predictor.sv
fetch_slot_stage.sv
inst_queue.sv
frontend.sv
tb_frontend.sv

/* frontend.sv */
// Two-wide fetch frontend over a synchronous instruction memory with one cycle
// of read latency. imem_rdata must hold its value while imem_re is low.
`default_nettype none

module frontend #(
   parameter int                P_FETCH_W  = 1,
   parameter int                P_ISSUE_W  = 1,
   parameter int                P_IQ_DEPTH = 3,
   parameter int                P_BTB_NUM  = 4,
   parameter frontend_pkg::pc_t PC_RST     = '0
) (
   input  logic                                        clk,
   input  logic                                        arst_n,
   input  logic                                        flush,
   input  frontend_pkg::pc_t                           flush_tgt,
   // Instruction memory
   output logic                                        imem_re,
   output logic [31:0]                                 imem_addr,
   input  frontend_pkg::insn_t [(1<<P_FETCH_W)-1:0]    imem_rdata,
   // From execute
   input  frontend_pkg::bpu_wb_t                       bpu_wb,
   // To decode
   output logic [(1<<P_ISSUE_W)-1:0]                   id_valid,
   output frontend_pkg::id_slot_t [(1<<P_ISSUE_W)-1:0] id_slot,
   input  logic [P_ISSUE_W:0]                          id_pop_cnt
);
   localparam int FW = 1 << P_FETCH_W;

   logic                              fetch_ce;
   logic                              iq_ready;
   frontend_pkg::pc_t [FW-1:0]        slot_pc;
   logic [FW-1:0]                     aligned;
   logic [P_FETCH_W:0]                push_offset;
   frontend_pkg::pred_t [FW-1:0]      pred;
   logic                              redirect_taken;
   frontend_pkg::pc_t                 redirect_tgt;
   logic [P_FETCH_W:0]                seq_cnt;
   logic [P_FETCH_W:0]                iq_push_cnt;
   logic [P_FETCH_W:0]                iq_push_offset;
   frontend_pkg::fetch_slot_t [FW-1:0] iq_slots;

   assign imem_re = fetch_ce;

   fetch_pc_gen #(
      .P_FETCH_W      (P_FETCH_W),
      .PC_RST         (PC_RST)
   ) pc_gen_i (
      .clk            (clk),
      .arst_n         (arst_n),
      .flush          (flush),
      .flush_tgt      (flush_tgt),
      .iq_ready       (iq_ready),
      .redirect_taken (redirect_taken),
      .redirect_tgt   (redirect_tgt),
      .seq_cnt        (seq_cnt),
      .fetch_ce       (fetch_ce),
      .imem_addr      (imem_addr),
      .slot_pc        (slot_pc),
      .aligned        (aligned),
      .push_offset    (push_offset)
   );

   branch_predictor #(
      .P_BTB_NUM      (P_BTB_NUM),
      .P_SLOTS        (FW)
   ) bpu_i (
      .clk            (clk),
      .arst_n         (arst_n),
      .fetch_ce       (fetch_ce),
      .slot_pc        (slot_pc),
      .wb             (bpu_wb),
      .pred           (pred)
   );

   fetch_slot_stage #(
      .P_FETCH_W      (P_FETCH_W)
   ) slot_stage_i (
      .clk            (clk),
      .arst_n         (arst_n),
      .fetch_ce       (fetch_ce),
      .flush          (flush),
      .slot_pc        (slot_pc),
      .aligned        (aligned),
      .push_offset    (push_offset),
      .pred           (pred),
      .imem_rdata     (imem_rdata),
      .redirect_taken (redirect_taken),
      .redirect_tgt   (redirect_tgt),
      .seq_cnt        (seq_cnt),
      .iq_push_cnt    (iq_push_cnt),
      .iq_push_offset (iq_push_offset),
      .iq_slots       (iq_slots)
   );

   inst_queue #(
      .P_FETCH_W      (P_FETCH_W),
      .P_ISSUE_W      (P_ISSUE_W),
      .P_IQ_DEPTH     (P_IQ_DEPTH)
   ) iq_i (
      .clk            (clk),
      .arst_n         (arst_n),
      .flush          (flush),
      .push_cnt       (iq_push_cnt),
      .push_offset    (iq_push_offset),
      .push_slots     (iq_slots),
      .pop_cnt        (id_pop_cnt),
      .iq_ready       (iq_ready),
      .id_valid       (id_valid),
      .id_slot        (id_slot)
   );

endmodule

`default_nettype wire

/* frontend_golden.txt */
// Fetch frontend script, hex fields per line: cmd a b c d
// F flush to PC a | B write-back kind a, taken b, pc c, next pc d | C pop mode a (1 all) b cycles
// E expect word PCs a, a+1, ... for b slots | D end
// Stream after reset starts at PC 0
E 0 10 0 0
// Even flush target, then odd flush target
F 20 0 0 0
E 20 6 0 0
F 35 0 0 0
E 35 5 0 0
// Taken conditional branch at 52 jumps to 71
B 0 1 52 71
F 4e 0 0 0
E 4e 5 0 0
E 71 4 0 0
// Two not-taken updates bring the counter down to 0
B 0 0 52 0
B 0 0 52 0
// Register-indirect branch at 54 is never allocated
B 2 1 54 10
F 50 0 0 0
E 50 8 0 0
// Decode stalls until the queue fills, then drains
C 0 14 0 0
E 58 a 0 0
C 1 8 0 0
D 0 0 0 0

/* frontend_pkg.sv */
// Shared types for the fetch frontend. PCs are word addresses, so the byte address
// is the PC with two zero bits appended.
`default_nettype none

package frontend_pkg;

   localparam int unsigned insn_w = 32;
   // Word PC, byte address without its two low bits
   localparam int unsigned pc_w = 30;

   typedef logic [pc_w-1:0]   pc_t;
   typedef logic [insn_w-1:0] insn_t;

   // Kind of a resolved branch reported by execute
   typedef enum logic [1:0] {
      BR_COND,
      BR_REL,
      BR_REG
   } br_kind_e;

   // Write-back update for the predictor
   typedef struct packed {
      logic     valid;
      br_kind_e kind;
      logic     taken;
      pc_t      pc;
      pc_t      npc_act;
   } bpu_wb_t;

   // Prediction attached to one slot
   typedef struct packed {
      logic taken;
      pc_t  target;
   } pred_t;

   // Slot entering the instruction queue
   typedef struct packed {
      pc_t   pc;
      insn_t ins;
      pred_t pred;
   } fetch_slot_t;

   // Slot handed to decode, kept apart so decode can carry more later
   typedef struct packed {
      pc_t   pc;
      insn_t ins;
      pred_t pred;
   } id_slot_t;

endpackage

`default_nettype wire

/* inst_queue.sv */
// Circular instruction queue. Pushes land one cycle before id_valid shows them;
// flush drops everything at the edge, including a push in the same cycle.
`default_nettype none

module inst_queue #(
   parameter int P_FETCH_W  = 1,
   parameter int P_ISSUE_W  = 1,
   parameter int P_IQ_DEPTH = 3
) (
   input  logic                                           clk,
   input  logic                                           arst_n,
   input  logic                                           flush,
   input  logic [P_FETCH_W:0]                             push_cnt,
   input  logic [P_FETCH_W:0]                             push_offset,
   input  frontend_pkg::fetch_slot_t [(1<<P_FETCH_W)-1:0] push_slots,
   input  logic [P_ISSUE_W:0]                             pop_cnt,
   output logic                                           iq_ready,
   output logic [(1<<P_ISSUE_W)-1:0]                      id_valid,
   output frontend_pkg::id_slot_t [(1<<P_ISSUE_W)-1:0]    id_slot
);
   localparam int FW    = 1 << P_FETCH_W;
   localparam int IW    = 1 << P_ISSUE_W;
   localparam int CW    = P_FETCH_W + 1;
   localparam int DEPTH = 1 << P_IQ_DEPTH;
   localparam int NW    = P_IQ_DEPTH + 1;

   frontend_pkg::fetch_slot_t mem [DEPTH];

   logic [P_IQ_DEPTH-1:0] head_q;
   logic [P_IQ_DEPTH-1:0] tail_q;
   logic [NW-1:0]         count_q;
   logic [NW-1:0]         free_cnt;
   logic [CW-1:0]         src_idx [FW];

   // Source slot for each write port, counted from the push offset
   always_comb
   begin
      for (int k = 0; k < FW; k++)
         src_idx[k] = (push_offset + CW'(k)) & CW'(FW - 1);
   end

   always_ff @(posedge clk)
   begin
      for (int k = 0; k < FW; k++)
      begin
         if (CW'(k) < push_cnt)
            mem[tail_q + P_IQ_DEPTH'(k)] <= push_slots[src_idx[k]];
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         head_q  <= '0;
         tail_q  <= '0;
         count_q <= '0;
      end
      else if (flush)
      begin
         head_q  <= '0;
         tail_q  <= '0;
         count_q <= '0;
      end
      else
      begin
         head_q  <= head_q + P_IQ_DEPTH'(pop_cnt);
         tail_q  <= tail_q + P_IQ_DEPTH'(push_cnt);
         count_q <= count_q + NW'(push_cnt) - NW'(pop_cnt);
      end
   end

   // Room for a whole window is needed before the next fetch
   assign free_cnt = NW'(DEPTH) - count_q;
   assign iq_ready = (free_cnt >= NW'(FW));

   generate
      for (genvar i = 0; i < IW; i++)
      begin : g_read
         assign id_valid[i] = (count_q > NW'(i));
         assign id_slot[i]  = frontend_pkg::id_slot_t'(mem[head_q + P_IQ_DEPTH'(i)]);
      end
   endgenerate

   a_no_overflow : assert property (@(posedge clk) disable iff (!arst_n)
      count_q <= NW'(DEPTH));

   // Decode may only pop what it was shown
   a_pop_in_range : assert property (@(posedge clk) disable iff (!arst_n)
      NW'(pop_cnt) <= count_q);

endmodule

`default_nettype wire

/* tb_frontend.sv */
// Self-checking testbench for the fetch frontend, stimulus from frontend_golden.txt.
// Run from the project root; inputs change on the falling clock edge.
`default_nettype none

module tb_frontend;

   localparam int P_FETCH_W  = 1;
   localparam int P_ISSUE_W  = 1;
   localparam int P_IQ_DEPTH = 3;
   localparam int P_BTB_NUM  = 4;
   localparam int BTB_NUM    = 1 << P_BTB_NUM;
   localparam int TAG_W      = frontend_pkg::pc_w - P_BTB_NUM;
   localparam int MAX_REC    = 64;
   localparam int REC_W      = 5;
   // Worst case to fill the queue, one slot per window plus the pipeline
   localparam int FILL_CYC   = (1 << P_IQ_DEPTH) + 4;

   logic                         clk;
   logic                         arst_n;
   logic                         flush;
   frontend_pkg::pc_t            flush_tgt;
   logic                         imem_re;
   logic [31:0]                  imem_addr;
   // Memory output starts cleared
   frontend_pkg::insn_t [1:0]    imem_rdata = '0;
   frontend_pkg::bpu_wb_t        bpu_wb;
   logic [1:0]                   id_valid;
   frontend_pkg::id_slot_t [1:0] id_slot;
   logic [P_ISSUE_W:0]           id_pop_cnt;

   logic [31:0]       gold [MAX_REC*REC_W];
   int unsigned       cycles;
   int unsigned       limit;
   // PC that the next popped slot must carry
   frontend_pkg::pc_t next_pc;

   // Reference model of the target buffer
   logic              m_vld [BTB_NUM];
   logic [TAG_W-1:0]  m_tag [BTB_NUM];
   frontend_pkg::pc_t m_tgt [BTB_NUM];
   logic [1:0]        m_cnt [BTB_NUM];

   frontend #(
      .P_FETCH_W  (P_FETCH_W),
      .P_ISSUE_W  (P_ISSUE_W),
      .P_IQ_DEPTH (P_IQ_DEPTH),
      .P_BTB_NUM  (P_BTB_NUM),
      .PC_RST     (frontend_pkg::pc_t'(0))
   ) dut_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .flush      (flush),
      .flush_tgt  (flush_tgt),
      .imem_re    (imem_re),
      .imem_addr  (imem_addr),
      .imem_rdata (imem_rdata),
      .bpu_wb     (bpu_wb),
      .id_valid   (id_valid),
      .id_slot    (id_slot),
      .id_pop_cnt (id_pop_cnt)
   );

   always #4 clk = ~clk;

   function automatic frontend_pkg::insn_t mem_word(input logic [31:0] byte_addr);
      return byte_addr ^ 32'hA5A50000;
   endfunction

   // Synchronous memory, one cycle of read latency, holds while idle
   always @(posedge clk)
   begin
      if (imem_re)
      begin
         compare("imem_addr[2:0]", imem_addr[2:0], 3'b000);
         imem_rdata <= {mem_word(imem_addr + 32'd4), mem_word(imem_addr)};
      end
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("tests failed");
      $fatal(1, "Run stopped");
   endtask

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("ERROR time %0t: %s is %h, expected %h", $time, name, got, exp);
         $display("tests failed");
         $fatal(1, "Value mismatch");
      end
   endtask

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= limit)
         abort_run($sformatf("Timeout, no end of script after %0d cycles", cycles));
   end

   // Decode must never see slot 1 without slot 0
   always @(negedge clk)
   begin
      if (arst_n && id_valid == 2'b10)
         abort_run("id_valid shows slot 1 without slot 0");
   end

   function automatic int valid_count();
      return int'(id_valid[0]) + int'(id_valid[1]);
   endfunction

   // Taken prediction that the model expects for a slot at pc
   function automatic logic model_taken(input frontend_pkg::pc_t pc);
      int idx;
      idx = int'(pc[P_BTB_NUM-1:0]);
      return m_vld[idx] && (m_tag[idx] == pc[frontend_pkg::pc_w-1:P_BTB_NUM]) &&
             (m_cnt[idx] >= 2'd2);
   endfunction

   // Stream successor of a slot, following the model's prediction
   function automatic frontend_pkg::pc_t model_next(input frontend_pkg::pc_t pc);
      if (model_taken(pc))
         return m_tgt[int'(pc[P_BTB_NUM-1:0])];
      return pc + 1'b1;
   endfunction

   task automatic btb_train(input frontend_pkg::br_kind_e kind, input logic taken,
                            input frontend_pkg::pc_t pc, input frontend_pkg::pc_t npc);
      int   idx;
      logic hit;
      idx = int'(pc[P_BTB_NUM-1:0]);
      hit = m_vld[idx] && (m_tag[idx] == pc[frontend_pkg::pc_w-1:P_BTB_NUM]);
      if (taken && kind != frontend_pkg::BR_REG)
      begin
         m_tgt[idx] = npc;
         if (!hit)
         begin
            m_vld[idx] = 1'b1;
            m_tag[idx] = pc[frontend_pkg::pc_w-1:P_BTB_NUM];
            m_cnt[idx] = 2'd2;
         end
         else if (m_cnt[idx] != 2'd3)
            m_cnt[idx] = m_cnt[idx] + 2'd1;
      end
      else if (!taken && hit && m_cnt[idx] != 2'd0)
         m_cnt[idx] = m_cnt[idx] - 2'd1;
   endtask

   // Head slot i against the expected PC, the memory contents and the model
   task automatic check_slot(input int i, input frontend_pkg::pc_t want);
      frontend_pkg::id_slot_t s;
      int                     idx;
      logic                   tk;
      s   = id_slot[i];
      idx = int'(s.pc[P_BTB_NUM-1:0]);
      tk  = model_taken(s.pc);
      compare($sformatf("id_slot[%0d].pc", i), s.pc, want);
      compare($sformatf("id_slot[%0d].ins", i), s.ins, mem_word({s.pc, 2'b00}));
      compare($sformatf("id_slot[%0d].pred.taken", i), s.pred.taken, tk);
      if (tk)
         compare($sformatf("id_slot[%0d].pred.target", i), s.pred.target, m_tgt[idx]);
   endtask

   task automatic pulse_flush(input frontend_pkg::pc_t tgt);
      @(negedge clk);
      flush      = 1'b1;
      flush_tgt  = tgt;
      id_pop_cnt = '0;
      next_pc    = tgt;
      @(negedge clk);
      flush = 1'b0;
   endtask

   task automatic pulse_wb(input frontend_pkg::br_kind_e kind, input logic taken,
                           input frontend_pkg::pc_t pc, input frontend_pkg::pc_t npc);
      @(negedge clk);
      bpu_wb.valid   = 1'b1;
      bpu_wb.kind    = kind;
      bpu_wb.taken   = taken;
      bpu_wb.pc      = pc;
      bpu_wb.npc_act = npc;
      id_pop_cnt     = '0;
      btb_train(kind, taken, pc, npc);
      @(negedge clk);
      bpu_wb.valid = 1'b0;
   endtask

   // Pops n slots in order, each one checked against the next expected PC
   task automatic pop_expected(input frontend_pkg::pc_t first, input int n);
      frontend_pkg::pc_t want;
      int                left;
      int                take;
      want = first;
      left = n;
      while (left > 0)
      begin
         @(negedge clk);
         take = valid_count();
         if (take > left)
            take = left;
         for (int i = 0; i < take; i++)
         begin
            check_slot(i, want);
            next_pc = model_next(want);
            want    = want + 1'b1;
         end
         id_pop_cnt = take[P_ISSUE_W:0];
         left       = left - take;
      end
   endtask

   task automatic run_pop_mode(input logic pop_all, input int n);
      int take;
      repeat (n)
      begin
         @(negedge clk);
         take = pop_all ? valid_count() : 0;
         for (int i = 0; i < take; i++)
         begin
            check_slot(i, next_pc);
            next_pc = model_next(next_pc);
         end
         id_pop_cnt = take[P_ISSUE_W:0];
      end
      // A long stall leaves the queue full, so fetch has stopped
      if (!pop_all && n > FILL_CYC)
         compare("imem_re", imem_re, 1'b0);
   endtask

   initial
   begin
      int          nrec;
      logic [31:0] cmd;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [31:0] d;
      clk        = 1'b0;
      arst_n     = 1'b0;
      flush      = 1'b0;
      flush_tgt  = '0;
      bpu_wb     = '0;
      id_pop_cnt = '0;
      cycles     = 0;
      next_pc    = '0;
      for (int k = 0; k < BTB_NUM; k++)
         m_vld[k] = 1'b0;
      $readmemh("frontend_golden.txt", gold);
      nrec = 0;
      while (nrec < MAX_REC && gold[nrec*REC_W] !== 32'hD && !$isunknown(gold[nrec*REC_W]))
         nrec++;
      if (nrec == MAX_REC || gold[nrec*REC_W] !== 32'hD)
         abort_run("Golden file is missing or has no end command");
      limit = 40 * (nrec + 1);

      repeat (3) @(negedge clk);
      arst_n = 1'b1;

      for (int r = 0; r < nrec; r++)
      begin
         cmd = gold[r*REC_W];
         a   = gold[r*REC_W+1];
         b   = gold[r*REC_W+2];
         c   = gold[r*REC_W+3];
         d   = gold[r*REC_W+4];
         case (cmd)
            32'hF: pulse_flush(a[29:0]);
            32'hB: pulse_wb(frontend_pkg::br_kind_e'(a[1:0]), b[0], c[29:0], d[29:0]);
            32'hC: run_pop_mode(a[0], int'(b));
            32'hE: pop_expected(a[29:0], int'(b));
            default: abort_run($sformatf("Unknown command %h on golden line %0d", cmd, r));
         endcase
      end
      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire
